// File: logic/host_cmd_pkg.sv
////////////////////////////////////////
// host command side definitions
// pipe-in word layout, command opcodes,
// error codes, decoder state encoding
////////////////////////////////////////

package host_cmd_pkg;

    // one pipe-in word, opcode byte on top
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] arg;
    } cmd_word_t;

    typedef logic [15:0] err_code_t;

    // full-word commands
    localparam logic [15:0] cmd_nop           = 16'h0000;
    localparam logic [15:0] cmd_version_major = 16'h0100;
    localparam logic [15:0] cmd_version_minor = 16'h0101;
    localparam logic [15:0] cmd_read_error    = 16'h0102;
    localparam logic [15:0] cmd_set_coeff     = 16'h0200;  // one operand word follows

    // error codes, one bit each except none
    localparam err_code_t err_none           = 16'd0;
    localparam err_code_t err_unknown_cmd    = 16'd1;
    localparam err_code_t err_resp_overflow  = 16'd2;
    localparam err_code_t err_read_empty     = 16'd4;
    localparam err_code_t err_board_mismatch = 16'd8;

    localparam logic [15:0] version_major          = 16'd1;
    localparam logic [15:0] version_minor          = 16'd2;
    localparam logic [15:0] expected_board_id      = 16'd800;
    localparam logic [15:0] expected_board_version = 16'd1;

    // decoder expects either an opcode or the coefficient operand
    typedef enum logic {
        st_opcode  = 1'b0,
        st_operand = 1'b1
    } dec_state_t;

endpackage

// File: logic/resp_pkg.sv
////////////////////////////////////////
// response side definitions
// response word, response count,
// host status word layout
////////////////////////////////////////

package resp_pkg;

    // one word sent back to the host
    typedef logic [15:0] resp_word_t;

    // number of pending responses, 10 bits so depth stays below 1024
    typedef logic [9:0] count_t;

    localparam int max_count = 1023;

    // status word as seen by the host
    typedef struct packed {
        logic [5:0] reserved;  // always zero
        count_t     count;     // fifo words plus output register
    } status_t;

endpackage

// File: logic/cmd_decoder.sv
////////////////////////////////////////
// cmd_decoder
// host command parser, coefficient load,
// last error tracking, response writes
////////////////////////////////////////

`timescale 1ns/100ps

module cmd_decoder #(
    parameter logic [15:0] board_id      = 16'd800,
    parameter logic [15:0] board_version = 16'd1
) (
    input  logic                    clk,
    input  logic                    reset,
    input  host_cmd_pkg::cmd_word_t pipe_in_data,
    input  logic                    pipe_in_en,
    input  logic                    overflow,    // response dropped by the fifo
    input  logic                    read_empty,  // host read with nothing presented
    output logic                    resp_wr,
    output resp_pkg::resp_word_t    resp_data,
    output logic [15:0]             coeff
);

    // error left after reset depends on the board we were built for
    localparam host_cmd_pkg::err_code_t boot_err =
        (board_id == host_cmd_pkg::expected_board_id &&
         board_version == host_cmd_pkg::expected_board_version) ?
        host_cmd_pkg::err_none : host_cmd_pkg::err_board_mismatch;

    host_cmd_pkg::cmd_word_t  in_word;   // registered pipe-in word
    logic                     in_valid;  // in_word holds a new word
    host_cmd_pkg::dec_state_t state;
    host_cmd_pkg::err_code_t  last_err;

    // input register, decode runs one cycle behind the host strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= pipe_in_en;
        end
        in_word <= pipe_in_data;
    end

    ////////////////////////////////////////
    // command decode

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= host_cmd_pkg::st_opcode;
            resp_wr <= 1'b0;
            coeff   <= 16'h0000;
        end else begin
            resp_wr <= 1'b0;                              // single cycle pulse
            if (in_valid) begin
                if (state == host_cmd_pkg::st_operand) begin
                    coeff <= in_word;                     // operand word of set_coeff
                    state <= host_cmd_pkg::st_opcode;
                end else begin
                    case (in_word)
                        host_cmd_pkg::cmd_version_major,
                        host_cmd_pkg::cmd_version_minor,
                        host_cmd_pkg::cmd_read_error: resp_wr <= 1'b1;
                        host_cmd_pkg::cmd_set_coeff:  state   <= host_cmd_pkg::st_operand;
                        default: begin
                        end                               // nop and unknowns emit nothing
                    endcase
                end
            end
        end
    end

    // response payload, only looked at when resp_wr is high
    always_ff @(posedge clk) begin
        case (in_word)
            host_cmd_pkg::cmd_version_major: resp_data <= host_cmd_pkg::version_major;
            host_cmd_pkg::cmd_version_minor: resp_data <= host_cmd_pkg::version_minor;
            default:                         resp_data <= last_err;  // read_error value
        endcase
    end

    ////////////////////////////////////////
    // error tracking, overflow wins, then empty read, then commands

    always_ff @(posedge clk) begin
        if (reset) begin
            last_err <= boot_err;
        end else if (overflow) begin
            last_err <= host_cmd_pkg::err_resp_overflow;
        end else if (read_empty) begin
            last_err <= host_cmd_pkg::err_read_empty;
        end else if (in_valid && state == host_cmd_pkg::st_opcode) begin
            case (in_word)
                host_cmd_pkg::cmd_nop,
                host_cmd_pkg::cmd_version_major,
                host_cmd_pkg::cmd_version_minor,
                host_cmd_pkg::cmd_set_coeff: begin
                end
                host_cmd_pkg::cmd_read_error: last_err <= host_cmd_pkg::err_none;  // read clears
                default:                      last_err <= host_cmd_pkg::err_unknown_cmd;
            endcase
        end
    end

    // an operand cycle never turns into a response
    a_no_resp_on_operand: assert property (@(posedge clk) disable iff (reset)
        state == host_cmd_pkg::st_operand |=> !$rose(resp_wr));

endmodule

// File: logic/resp_fifo.sv
////////////////////////////////////////
// resp_fifo
// circular response store, payload type
// set by the instance, overflow flag
////////////////////////////////////////

`timescale 1ns/100ps

module resp_fifo #(
    parameter int  resp_depth = 10,
    parameter type payload_t  = logic [15:0]
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr,
    input  payload_t         wr_data,
    input  logic             pop,
    output payload_t         rd_data,    // head word, valid while not empty
    output logic             empty,
    output logic             overflow,   // write dropped this cycle
    output resp_pkg::count_t count
);

    // one word of the depth lives in the output register downstream
    localparam int store_depth = resp_depth - 1;
    localparam int ptr_w       = (store_depth > 1) ? $clog2(store_depth) : 1;

    if (resp_depth < 2 || resp_depth > resp_pkg::max_count) begin : g_depth_check
        $error("resp_fifo depth out of range");
    end

    payload_t         mem [store_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             full;
    logic             accept;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(store_depth - 1)) begin
            return '0;                                    // wrap
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == resp_pkg::count_t'(store_depth));
    assign empty    = (count == '0);
    assign accept   = wr && (!full || pop);               // a pop makes room the same cycle
    assign overflow = wr && !accept;
    assign rd_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // pointers and count

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (accept) wr_ptr <= next_ptr(wr_ptr);
            if (pop)    rd_ptr <= next_ptr(rd_ptr);
            case ({accept, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                  // both or neither
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);
    a_count_bound:  assert property (@(posedge clk) disable iff (reset)
        count <= resp_pkg::count_t'(store_depth));

endmodule

// File: logic/pipe_out_stage.sv
////////////////////////////////////////
// pipe_out_stage
// host output register, refill from the
// response fifo, empty read detection
////////////////////////////////////////

`timescale 1ns/100ps

module pipe_out_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  resp_pkg::resp_word_t rd_data,
    input  logic                 empty,
    output logic                 pop,
    input  logic                 pipe_out_read,
    output resp_pkg::resp_word_t pipe_out_data,
    output logic                 pipe_out_valid,
    output logic                 read_empty
);

    logic slot_free;  // register empty or being read this cycle

    assign slot_free  = !pipe_out_valid || pipe_out_read;
    assign pop        = slot_free && !empty;
    assign read_empty = pipe_out_read && !pipe_out_valid;  // host read nothing

    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_out_valid <= 1'b0;
        end else if (slot_free) begin
            pipe_out_valid <= !empty;                     // refill or go idle
        end
    end

    // payload follows the pop
    always_ff @(posedge clk) begin
        if (pop) begin
            pipe_out_data <= rd_data;
        end
    end

endmodule

// File: logic/stim_ctrl_top.sv
////////////////////////////////////////
// stim_ctrl_top
// command decoder, response fifo and
// output stage, host status word
////////////////////////////////////////

`timescale 1ns/100ps

module stim_ctrl_top #(
    parameter int          resp_depth    = 10,
    parameter logic [15:0] board_id      = 16'd800,
    parameter logic [15:0] board_version = 16'd1
) (
    input  logic                    clk,
    input  logic                    reset,
    input  host_cmd_pkg::cmd_word_t pipe_in_data,
    input  logic                    pipe_in_en,
    input  logic                    pipe_out_read,
    output resp_pkg::resp_word_t    pipe_out_data,
    output logic                    pipe_out_valid,
    output logic [15:0]             coeff,
    output resp_pkg::status_t       status
);

    logic                 resp_wr;
    resp_pkg::resp_word_t resp_data;
    logic                 overflow;
    logic                 read_empty;
    logic                 pop;
    resp_pkg::resp_word_t rd_data;
    logic                 empty;
    resp_pkg::count_t     fifo_count;

    cmd_decoder #(
        .board_id      (board_id),
        .board_version (board_version)
    ) cmd_decoder_inst (
        .clk           (clk),
        .reset         (reset),
        .pipe_in_data  (pipe_in_data),
        .pipe_in_en    (pipe_in_en),
        .overflow      (overflow),
        .read_empty    (read_empty),
        .resp_wr       (resp_wr),
        .resp_data     (resp_data),
        .coeff         (coeff)
    );

    resp_fifo #(
        .resp_depth (resp_depth),
        .payload_t  (resp_pkg::resp_word_t)
    ) resp_fifo_inst (
        .clk      (clk),
        .reset    (reset),
        .wr       (resp_wr),
        .wr_data  (resp_data),
        .pop      (pop),
        .rd_data  (rd_data),
        .empty    (empty),
        .overflow (overflow),
        .count    (fifo_count)
    );

    pipe_out_stage pipe_out_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .rd_data        (rd_data),
        .empty          (empty),
        .pop            (pop),
        .pipe_out_read  (pipe_out_read),
        .pipe_out_data  (pipe_out_data),
        .pipe_out_valid (pipe_out_valid),
        .read_empty     (read_empty)
    );

    // pending count includes the word held for the host
    assign status.reserved = '0;
    assign status.count    = fifo_count + resp_pkg::count_t'(pipe_out_valid);

    // fifo and output register together never hold more than the depth
    a_status_bound: assert property (@(posedge clk) disable iff (reset)
        status.count <= resp_pkg::count_t'(resp_depth));

endmodule

// File: testbench/tb_clock_gen.sv
////////////////////////////////////////
// testbench clock and reset source
////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // reset drops on a falling edge, same as the other stimulus
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: testbench/stim_ctrl_tb.sv
////////////////////////////////////////
// testbench for stim_ctrl_top
// command stimulus, reference model,
// response compare, watchdog, summary
////////////////////////////////////////

`timescale 1ns/100ps

module stim_ctrl_tb;

    localparam int clk_period_ns   = 4;
    localparam int watchdog_cycles = 2000;
    localparam int resp_depth      = 10;  // top level default
    localparam int wait_limit      = 50;  // cycles allowed for any one wait

    logic                    clk;
    logic                    reset;
    host_cmd_pkg::cmd_word_t pipe_in_data;
    logic                    pipe_in_en;
    logic                    pipe_out_read;
    resp_pkg::resp_word_t    pipe_out_data;
    logic                    pipe_out_valid;
    logic [15:0]             coeff;
    resp_pkg::status_t       status;

    resp_pkg::resp_word_t expected_q[$];  // words the host should see, in order
    resp_pkg::resp_word_t expected_word;
    logic [15:0]          model_err;      // modelled last error
    int                   model_pending;  // fifo plus output register
    logic [31:0]          rng_state;
    int                   error_count;
    int                   compare_count;

    tb_clock_gen #(
        .period_ns    (clk_period_ns),
        .reset_cycles (8)
    ) tb_clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    stim_ctrl_top stim_ctrl_top_inst (
        .clk            (clk),
        .reset          (reset),
        .pipe_in_data   (pipe_in_data),
        .pipe_in_en     (pipe_in_en),
        .pipe_out_read  (pipe_out_read),
        .pipe_out_data  (pipe_out_data),
        .pipe_out_valid (pipe_out_valid),
        .coeff          (coeff),
        .status         (status)
    );

    ////////////////////////////////////////
    // reference model

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic is_known_cmd(input logic [15:0] w);
        return w == host_cmd_pkg::cmd_nop || w == host_cmd_pkg::cmd_version_major ||
               w == host_cmd_pkg::cmd_version_minor || w == host_cmd_pkg::cmd_read_error ||
               w == host_cmd_pkg::cmd_set_coeff;
    endfunction

    // response for one command word, err updated in place, returns 1 if a word is sent
    function automatic logic ref_command(input logic [15:0] cmd, inout logic [15:0] err,
                                         output logic [15:0] resp);
        logic has_resp;
        has_resp = 1'b0;
        resp     = 16'h0000;
        case (cmd)
            host_cmd_pkg::cmd_version_major: begin
                resp     = host_cmd_pkg::version_major;
                has_resp = 1'b1;
            end
            host_cmd_pkg::cmd_version_minor: begin
                resp     = host_cmd_pkg::version_minor;
                has_resp = 1'b1;
            end
            host_cmd_pkg::cmd_read_error: begin
                resp     = err;                        // value before the clear
                err      = host_cmd_pkg::err_none;
                has_resp = 1'b1;
            end
            host_cmd_pkg::cmd_nop, host_cmd_pkg::cmd_set_coeff: begin
            end
            default: err = host_cmd_pkg::err_unknown_cmd;
        endcase
        return has_resp;
    endfunction

    ////////////////////////////////////////
    // stimulus tasks, all driving on the falling edge

    task automatic send_word(input logic [15:0] w);
        @(negedge clk);
        pipe_in_data = w;
        pipe_in_en   = 1'b1;
        @(negedge clk);
        pipe_in_en   = 1'b0;
    endtask

    task automatic send_command(input logic [15:0] cmd);
        logic [15:0] resp;
        if (ref_command(cmd, model_err, resp)) begin
            if (model_pending < resp_depth) begin
                expected_q.push_back(resp);
                model_pending++;
            end else begin
                model_err = host_cmd_pkg::err_resp_overflow;  // full, word lost
            end
        end
        send_word(cmd);
    endtask

    task automatic read_response();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!pipe_out_valid && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!pipe_out_valid) begin
            error_count++;
            $display("no response was presented to the host within %0d cycles", wait_limit);
        end else begin
            pipe_out_read = 1'b1;
            @(negedge clk);
            pipe_out_read = 1'b0;
        end
    endtask

    task automatic wait_count(input int n);
        int cycles;
        cycles = 0;
        while (int'(status.count) != n && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (int'(status.count) != n) begin
            error_count++;
            $display("status count stayed at %0d, never reached %0d", status.count, n);
        end
    endtask

    task automatic check_status(input int n);
        if (status.count !== resp_pkg::count_t'(n)) begin
            error_count++;
            $display("CHECK FAILED at %0t: status count %0d, expected %0d",
                     $time, status.count, n);
        end
        if (status.reserved !== 6'b000000) begin
            error_count++;
            $display("CHECK FAILED at %0t: status reserved bits %b, expected zero",
                     $time, status.reserved);
        end
    endtask

    ////////////////////////////////////////
    // compare every host read against the model

    always @(posedge clk) begin
        if (!reset && pipe_out_read && pipe_out_valid) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("host read a word that the model never produced");
            end else begin
                expected_word = expected_q.pop_front();
                model_pending--;
                compare_count++;
                if (pipe_out_data !== expected_word) begin
                    error_count++;
                    $display("CHECK FAILED at %0t: response %h, expected %h",
                             $time, pipe_out_data, expected_word);
                end
            end
        end
    end

    initial begin : stimulus
        logic [15:0] operand;
        logic [15:0] unknown;
        pipe_in_data  = '0;
        pipe_in_en    = 1'b0;
        pipe_out_read = 1'b0;
        rng_state     = 32'h4f8f_87a4;
        model_err     = host_cmd_pkg::err_none;  // default board values match
        model_pending = 0;
        error_count   = 0;
        compare_count = 0;
        @(negedge clk);
        while (reset) @(negedge clk);

        // error after reset
        send_command(host_cmd_pkg::cmd_read_error);
        read_response();

        // versions, count up then down
        send_command(host_cmd_pkg::cmd_version_major);
        send_command(host_cmd_pkg::cmd_version_minor);
        wait_count(2);
        read_response();
        check_status(1);
        read_response();
        check_status(0);

        ////////////////////////////////////////
        // coefficient load, no response
        rng_state = xorshift32(rng_state);
        operand   = rng_state[15:0];
        send_command(host_cmd_pkg::cmd_set_coeff);
        send_word(operand);
        for (int i = 0; i < wait_limit && coeff !== operand; i++) @(negedge clk);
        if (coeff !== operand) begin
            error_count++;
            $display("CHECK FAILED at %0t: coeff %h, expected %h", $time, coeff, operand);
        end
        repeat (4) @(negedge clk);
        check_status(0);

        // unknown opcode, then the error reads back once
        do begin
            rng_state = xorshift32(rng_state);
            unknown   = rng_state[31:16];
        end while (is_known_cmd(unknown));
        send_command(unknown);
        send_command(host_cmd_pkg::cmd_read_error);
        send_command(host_cmd_pkg::cmd_read_error);
        wait_count(2);
        read_response();
        read_response();

        ////////////////////////////////////////
        // overflow: 12 queries, only the depth survives
        for (int i = 0; i < 12; i++) begin
            send_command((i % 2 == 1) ? host_cmd_pkg::cmd_version_minor
                                      : host_cmd_pkg::cmd_version_major);
        end
        wait_count(resp_depth);
        repeat (6) @(negedge clk);
        check_status(resp_depth);
        repeat (resp_depth) read_response();
        check_status(0);
        send_command(host_cmd_pkg::cmd_read_error);
        read_response();

        // read with nothing presented, model holds no word here
        @(negedge clk);
        pipe_out_read = 1'b1;
        model_err     = host_cmd_pkg::err_read_empty;
        @(negedge clk);
        pipe_out_read = 1'b0;
        send_command(host_cmd_pkg::cmd_read_error);
        read_response();

        repeat (4) @(negedge clk);
        if (expected_q.size() != 0) begin
            error_count++;
            $display("%0d expected responses never reached the host", expected_q.size());
        end
        $display("summary: %0d responses compared, %0d errors", compare_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // hard stop well past the length of all tests
    initial begin : watchdog
        #(watchdog_cycles * clk_period_ns);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: flist.f
logic/host_cmd_pkg.sv
logic/resp_pkg.sv
logic/cmd_decoder.sv
logic/resp_fifo.sv
logic/pipe_out_stage.sv
logic/stim_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/stim_ctrl_tb.sv

// File: Makefile
# Verilator simulation of the host command side

VERILATOR ?= verilator
TOP       ?= stim_ctrl_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
